// File: Makefile
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+10

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: include/rv_id_macros.svh
`ifndef RV_ID_MACROS_SVH
`define RV_ID_MACROS_SVH

// ==============================
// rv32i major opcodes
// ==============================
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011

// ==============================
// funct3 / funct7 codes
// ==============================
`define RV_F3_ADD     3'b000  // add, sub, addi
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101  // srl / sra, split by funct7
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111
`define RV_F3_B       3'b000  // byte access, loads and stores
`define RV_F3_H       3'b001
`define RV_F3_W       3'b010
`define RV_F3_BU      3'b100  // unsigned loads only
`define RV_F3_HU      3'b101
`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000  // sub, sra

`define RV_NUM_REGS   32
`define RV_RESET_PC   32'h0000_0000

`endif

// File: logic/id_stage.sv
`timescale 1ns/1ps
`include "rv_id_macros.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   fetch_valid_i,
    input  rv_id_pkg::fetch_pkt_t  fetch_i,
    input  rv_id_pkg::wb_pkt_t     wb_i,
    input  logic                   rs1_busy_i,
    output logic                   ex_valid_o,
    output rv_id_pkg::id_ex_pkt_t  ex_o,
    output logic                   redirect_valid_o,
    output rv_id_pkg::redirect_t   redirect_o
);
    import rv_id_pkg::*;

    // ==============================
    // decode side
    // ==============================
    dec_ctrl_t  ctrl;
    logic       illegal;
    xlen_t      imm;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    redirect_t  pred;
    redirect_t  redirect_d;
    id_ex_pkt_t ex_d;

    rv_decoder u_decoder (
        .instr_i   (fetch_i.instr),
        .ctrl_o    (ctrl),
        .illegal_o (illegal)
    );

    imm_extender u_imm_extender (
        .instr_i    (fetch_i.instr),
        .imm_type_i (ctrl.imm_type),
        .imm_o      (imm)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .resetn     (resetn),
        .rs1_i      (fetch_i.instr[19:15]),
        .rs2_i      (fetch_i.instr[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_i)
    );

    static_branch_predictor u_predictor (
        .kind_i     (ctrl.branch_kind),
        .pc_i       (fetch_i.pc),
        .rs1_data_i (rs1_data),
        .imm_i      (imm),
        .rs1_busy_i (rs1_busy_i),
        .redirect_o (pred)
    );

    // illegal op never redirects fetch
    assign redirect_d.taken  = pred.taken && !illegal;
    assign redirect_d.target = pred.target;

    // next execute packet, operand muxes
    always_comb begin
        ex_d.alu_op   = ctrl.alu_op;
        ex_d.op_a     = (ctrl.op_a_sel == OP_A_PC)  ? fetch_i.pc : rs1_data;
        ex_d.op_b     = (ctrl.op_b_sel == OP_B_IMM) ? imm        : rs2_data;
        ex_d.imm      = imm;
        ex_d.pc_plus4 = fetch_i.pc_plus4;
        ex_d.funct3   = ctrl.funct3;
        ex_d.mem_type = ctrl.mem_type;
        ex_d.wb_src   = ctrl.wb_src;
        ex_d.wb_en    = ctrl.wb_en;  // already cleared by decoder when illegal
        ex_d.rd       = fetch_i.instr[11:7];
        ex_d.illegal  = illegal;
    end

    // ==============================
    // decode to execute register
    // ==============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid_o        <= 1'b0;
            redirect_valid_o  <= 1'b0;
            ex_o              <= '0;
            redirect_o.taken  <= 1'b0;
            redirect_o.target <= `RV_RESET_PC;
        end else begin
            ex_valid_o       <= fetch_valid_i;  // one-cycle strobe, no stall
            redirect_valid_o <= fetch_valid_i && redirect_d.taken;
            if (fetch_valid_i) begin
                ex_o       <= ex_d;
                redirect_o <= redirect_d;  // held until next strobe
            end
        end
    end

endmodule

// File: logic/imm_extender.sv
`timescale 1ns/1ps

module imm_extender (
    input  rv_id_pkg::instr_t    instr_i,
    input  rv_id_pkg::imm_type_e imm_type_i,
    output rv_id_pkg::xlen_t     imm_o
);
    import rv_id_pkg::*;

    logic sign;

    assign sign = instr_i[31];  // every format keeps its sign in bit 31

    always_comb begin
        case (imm_type_i)
            IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            // b offset is even, bit 0 implied zero
            IMM_B: imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
            IMM_U: imm_o = {instr_i[31:12], 12'b0};  // upper 20 bits
            IMM_J: imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                            instr_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps
`include "rv_id_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                resetn,
    input  rv_id_pkg::reg_idx_t rs1_i,
    input  rv_id_pkg::reg_idx_t rs2_i,
    output rv_id_pkg::xlen_t    rs1_data_o,
    output rv_id_pkg::xlen_t    rs2_data_o,
    input  rv_id_pkg::wb_pkt_t  wb_i
);
    import rv_id_pkg::*;

    xlen_t regs [`RV_NUM_REGS];  // entry 0 never written

    // write port, visible to reads next cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.en && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;  // x0 writes dropped
        end
    end

    // read ports, no bypass from wb_i
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: logic/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_id_macros.svh"

module rv_decoder (
    input  rv_id_pkg::instr_t    instr_i,
    output rv_id_pkg::dec_ctrl_t ctrl_o,
    output logic                 illegal_o
);
    import rv_id_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // shared alu map for op and op-imm, alt picks sub / sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            `RV_F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            `RV_F3_SLL:  op = ALU_SLL;
            `RV_F3_SLT:  op = ALU_SLT;
            `RV_F3_SLTU: op = ALU_SLTU;
            `RV_F3_XOR:  op = ALU_XOR;
            `RV_F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            `RV_F3_OR:   op = ALU_OR;
            default:     op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // defaults: reg-reg add, no memory, no writeback
        ctrl_o.alu_op      = ALU_ADD;
        ctrl_o.op_a_sel    = OP_A_RS1;
        ctrl_o.op_b_sel    = OP_B_RS2;
        ctrl_o.imm_type    = IMM_I;
        ctrl_o.branch_kind = BR_NONE;
        ctrl_o.funct3      = funct3;
        ctrl_o.mem_type    = MEM_NONE;
        ctrl_o.wb_src      = WB_ALU;
        ctrl_o.wb_en       = 1'b0;
        illegal_o          = 1'b0;

        case (opcode)
            `RV_OP_LUI: begin
                ctrl_o.alu_op   = ALU_PASS_B;
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.imm_type = IMM_U;
                ctrl_o.wb_en    = 1'b1;
            end
            `RV_OP_AUIPC: begin
                ctrl_o.op_a_sel = OP_A_PC;  // pc + upper imm
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.imm_type = IMM_U;
                ctrl_o.wb_en    = 1'b1;
            end
            `RV_OP_JAL: begin
                ctrl_o.op_a_sel    = OP_A_PC;
                ctrl_o.op_b_sel    = OP_B_IMM;
                ctrl_o.imm_type    = IMM_J;
                ctrl_o.branch_kind = BR_JAL;
                ctrl_o.wb_src      = WB_PC4;  // link value
                ctrl_o.wb_en       = 1'b1;
            end
            `RV_OP_JALR: begin
                ctrl_o.op_b_sel    = OP_B_IMM;
                ctrl_o.branch_kind = BR_JALR;
                ctrl_o.wb_src      = WB_PC4;
                ctrl_o.wb_en       = 1'b1;
                illegal_o          = (funct3 != 3'b000);
            end
            `RV_OP_BRANCH: begin
                ctrl_o.imm_type    = IMM_B;
                ctrl_o.branch_kind = BR_BRANCH;
                case (funct3[2:1])  // compare flavour for execute
                    2'b00:   ctrl_o.alu_op = ALU_SUB;   // beq / bne
                    2'b10:   ctrl_o.alu_op = ALU_SLT;   // blt / bge
                    2'b11:   ctrl_o.alu_op = ALU_SLTU;  // bltu / bgeu
                    default: illegal_o = 1'b1;
                endcase
            end
            `RV_OP_LOAD: begin
                ctrl_o.op_b_sel = OP_B_IMM;  // address = rs1 + imm
                ctrl_o.wb_src   = WB_MEM;
                ctrl_o.wb_en    = 1'b1;
                case (funct3)
                    `RV_F3_B:  ctrl_o.mem_type = MEM_LB;
                    `RV_F3_H:  ctrl_o.mem_type = MEM_LH;
                    `RV_F3_W:  ctrl_o.mem_type = MEM_LW;
                    `RV_F3_BU: ctrl_o.mem_type = MEM_LBU;
                    `RV_F3_HU: ctrl_o.mem_type = MEM_LHU;
                    default:   illegal_o = 1'b1;
                endcase
            end
            `RV_OP_STORE: begin
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.imm_type = IMM_S;
                case (funct3)
                    `RV_F3_B: ctrl_o.mem_type = MEM_SB;
                    `RV_F3_H: ctrl_o.mem_type = MEM_SH;
                    `RV_F3_W: ctrl_o.mem_type = MEM_SW;
                    default:  illegal_o = 1'b1;
                endcase
            end
            `RV_OP_IMM: begin
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.wb_en    = 1'b1;
                ctrl_o.alu_op   = alu_sel(funct3, (funct3 == `RV_F3_SR) && funct7[5]);
                // only shifts carry a funct7 field in op-imm
                if (funct3 == `RV_F3_SLL) begin
                    illegal_o = (funct7 != `RV_F7_BASE);
                end else if (funct3 == `RV_F3_SR) begin
                    illegal_o = (funct7 != `RV_F7_BASE) && (funct7 != `RV_F7_ALT);
                end
            end
            `RV_OP_REG: begin
                ctrl_o.wb_en  = 1'b1;
                ctrl_o.alu_op = alu_sel(funct3, funct7[5]);
                illegal_o     = (funct7 != `RV_F7_BASE) &&
                                !((funct7 == `RV_F7_ALT) &&
                                  (funct3 == `RV_F3_ADD || funct3 == `RV_F3_SR));
            end
            default: illegal_o = 1'b1;  // csr, fence, system, unknown
        endcase

        // illegal op must not touch state downstream
        if (illegal_o) begin
            ctrl_o.wb_en    = 1'b0;
            ctrl_o.mem_type = MEM_NONE;
        end
    end

endmodule

// File: logic/rv_id_pkg.sv
package rv_id_pkg;

    // ==============================
    // plain width types
    // ==============================
    typedef logic [31:0] xlen_t;     // data / address word
    typedef logic [4:0]  reg_idx_t;  // x0..x31
    typedef logic [31:0] instr_t;

    // ==============================
    // control encodings
    // ==============================
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS_B  // lui, result is operand b
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;
    typedef enum logic {OP_A_RS1, OP_A_PC} op_a_sel_e;
    typedef enum logic {OP_B_RS2, OP_B_IMM} op_b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_src_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
        MEM_SB, MEM_SH, MEM_SW
    } mem_type_e;

    typedef enum logic [1:0] {BR_NONE, BR_BRANCH, BR_JAL, BR_JALR} branch_kind_e;

    // ==============================
    // stage packets
    // ==============================
    typedef struct packed {
        instr_t instr;
        xlen_t  pc;
        xlen_t  pc_plus4;
    } fetch_pkt_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        xlen_t    data;
    } wb_pkt_t;

    typedef struct packed {
        logic  taken;
        xlen_t target;
    } redirect_t;

    typedef struct packed {
        alu_op_e      alu_op;
        op_a_sel_e    op_a_sel;
        op_b_sel_e    op_b_sel;
        imm_type_e    imm_type;
        branch_kind_e branch_kind;
        logic [2:0]   funct3;    // compare / access size for execute
        mem_type_e    mem_type;
        wb_src_e      wb_src;
        logic         wb_en;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_e    alu_op;
        xlen_t      op_a;
        xlen_t      op_b;
        xlen_t      imm;
        xlen_t      pc_plus4;
        logic [2:0] funct3;
        mem_type_e  mem_type;
        wb_src_e    wb_src;
        logic       wb_en;
        reg_idx_t   rd;
        logic       illegal;
    } id_ex_pkt_t;

endpackage

// File: logic/static_branch_predictor.sv
`timescale 1ns/1ps

module static_branch_predictor (
    input  rv_id_pkg::branch_kind_e kind_i,
    input  rv_id_pkg::xlen_t        pc_i,
    input  rv_id_pkg::xlen_t        rs1_data_i,
    input  rv_id_pkg::xlen_t        imm_i,
    input  logic                    rs1_busy_i,
    output rv_id_pkg::redirect_t    redirect_o
);
    import rv_id_pkg::*;

    xlen_t pc_target;   // branch / jal
    xlen_t reg_target;  // jalr

    assign pc_target  = pc_i + imm_i;
    assign reg_target = (rs1_data_i + imm_i) & ~32'h1;  // lsb cleared per isa

    always_comb begin
        redirect_o.taken  = 1'b0;
        redirect_o.target = pc_target;
        case (kind_i)
            BR_BRANCH: redirect_o.taken = imm_i[31];  // backward taken, forward not
            BR_JAL:    redirect_o.taken = 1'b1;
            BR_JALR: begin
                // rs1 still in flight, target unknown, let execute resolve
                redirect_o.taken  = !rs1_busy_i;
                redirect_o.target = reg_target;
            end
            default:   redirect_o.taken = 1'b0;
        endcase
    end

endmodule

// File: tb.f
+incdir+include
logic/rv_id_pkg.sv
logic/rv_decoder.sv
logic/imm_extender.sv
logic/reg_file.sv
logic/static_branch_predictor.sv
logic/id_stage.sv
test/id_stage_checker.sv
test/tb_id_stage.sv

// File: test/id_stage_checker.sv
`timescale 1ns/1ps
`include "rv_id_macros.svh"

module id_stage_checker (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  fetch_valid_i,
    input  rv_id_pkg::fetch_pkt_t fetch_i,
    input  rv_id_pkg::wb_pkt_t    wb_i,
    input  logic                  rs1_busy_i,
    input  logic                  ex_valid_o,
    input  rv_id_pkg::id_ex_pkt_t ex_o,
    input  logic                  redirect_valid_o,
    input  rv_id_pkg::redirect_t  redirect_o
);
    import rv_id_pkg::*;

    xlen_t       shadow [`RV_NUM_REGS];  // register writes seen on wb_i
    logic        prev_valid;
    logic        prev_busy;
    fetch_pkt_t  prev_f;
    xlen_t       prev_rs1v;
    xlen_t       prev_rs2v;
    logic        fail_flag = 1'b0;       // polled by the testbench
    string       fail_name;
    logic [63:0] fail_exp;
    logic [63:0] fail_act;

    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    xlen_t       imm_i;
    xlen_t       imm_s;
    xlen_t       imm_b;
    xlen_t       imm_u;
    xlen_t       imm_j;
    xlen_t       exp_a;
    xlen_t       exp_b;
    xlen_t       exp_imm;
    xlen_t       exp_target;
    alu_op_e     exp_alu;
    mem_type_e   exp_mem;
    wb_src_e     exp_src;
    logic        exp_wb;
    logic        exp_ill;
    logic        exp_taken;
    logic        chk_a;
    logic        chk_b;
    logic        chk_imm;
    logic        chk_alu;
    logic [47:0] exp_ctrl;
    logic [47:0] act_ctrl;

    // ==============================
    // shadow state, one cycle back
    // ==============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                shadow[i] <= '0;
            end
            prev_valid <= 1'b0;
        end else begin
            if (wb_i.en && (wb_i.rd != 5'd0)) begin
                shadow[wb_i.rd] <= wb_i.data;  // x0 stays zero
            end
            prev_valid <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        prev_f    <= fetch_i;
        prev_busy <= rs1_busy_i;
        // old value, write of the same edge not yet visible
        prev_rs1v <= (fetch_i.instr[19:15] == 5'd0) ? '0 : shadow[fetch_i.instr[19:15]];
        prev_rs2v <= (fetch_i.instr[24:20] == 5'd0) ? '0 : shadow[fetch_i.instr[24:20]];
    end

    // ==============================
    // expected decode of prev_f
    // ==============================
    assign opc   = prev_f.instr[6:0];
    assign f3    = prev_f.instr[14:12];
    assign f7    = prev_f.instr[31:25];
    assign imm_i = xlen_t'($signed(prev_f.instr) >>> 20);  // arithmetic shift sign-fills
    assign imm_s = {imm_i[31:5], prev_f.instr[11:7]};
    assign imm_b = {imm_i[31:12], prev_f.instr[7], prev_f.instr[30:25],
                    prev_f.instr[11:8], 1'b0};
    assign imm_u = {prev_f.instr[31:12], 12'h000};
    assign imm_j = {imm_i[31:20], prev_f.instr[19:12], prev_f.instr[20],
                    prev_f.instr[30:21], 1'b0};

    function automatic alu_op_e alu_for_f3(input logic [2:0] f);
        case (f)
            3'b000:  return ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        exp_ill    = 1'b0;
        exp_wb     = 1'b1;
        exp_mem    = MEM_NONE;
        exp_src    = WB_ALU;
        exp_taken  = 1'b0;
        exp_target = prev_f.pc + imm_b;
        exp_a      = prev_rs1v;
        exp_b      = prev_rs2v;
        exp_imm    = imm_i;
        exp_alu    = alu_for_f3(f3);
        chk_a      = 1'b0;
        chk_b      = 1'b0;
        chk_imm    = 1'b0;
        chk_alu    = 1'b0;
        case (opc)
            `RV_OP_REG: begin
                {chk_a, chk_b, chk_alu} = 3'b111;
                if (f7 == 7'h20 && f3 == 3'b000) exp_alu = ALU_SUB;
                else if (f7 == 7'h20 && f3 == 3'b101) exp_alu = ALU_SRA;
                else exp_ill = (f7 != 7'h00);
            end
            `RV_OP_IMM: begin
                {chk_a, chk_b, chk_imm, chk_alu} = 4'b1111;
                exp_b = imm_i;
                if (f3 == 3'b101 && f7 == 7'h20) exp_alu = ALU_SRA;
                else if (f3 == 3'b001 || f3 == 3'b101) exp_ill = (f7 != 7'h00);
            end
            `RV_OP_LUI: begin
                {chk_b, chk_imm, chk_alu} = 3'b111;
                exp_imm = imm_u;
                exp_b   = imm_u;
                exp_alu = ALU_PASS_B;
            end
            `RV_OP_AUIPC: begin
                {chk_a, chk_b, chk_imm} = 3'b111;
                exp_a   = prev_f.pc;
                exp_imm = imm_u;
                exp_b   = imm_u;
            end
            `RV_OP_LOAD: begin
                {chk_a, chk_imm} = 2'b11;
                exp_src = WB_MEM;
                case (f3)
                    3'b000:  exp_mem = MEM_LB;
                    3'b001:  exp_mem = MEM_LH;
                    3'b010:  exp_mem = MEM_LW;
                    3'b100:  exp_mem = MEM_LBU;
                    3'b101:  exp_mem = MEM_LHU;
                    default: exp_ill = 1'b1;
                endcase
            end
            `RV_OP_STORE: begin
                {chk_a, chk_b, chk_imm} = 3'b111;
                exp_wb  = 1'b0;
                exp_imm = imm_s;
                exp_b   = imm_s;
                case (f3)
                    3'b000:  exp_mem = MEM_SB;
                    3'b001:  exp_mem = MEM_SH;
                    3'b010:  exp_mem = MEM_SW;
                    default: exp_ill = 1'b1;
                endcase
            end
            `RV_OP_BRANCH: begin
                chk_imm   = 1'b1;
                exp_wb    = 1'b0;
                exp_imm   = imm_b;
                exp_taken = imm_b[31];  // backward only
                exp_ill   = (f3 == 3'b010) || (f3 == 3'b011);
            end
            `RV_OP_JAL: begin
                chk_imm    = 1'b1;
                exp_imm    = imm_j;
                exp_src    = WB_PC4;
                exp_taken  = 1'b1;
                exp_target = prev_f.pc + imm_j;
            end
            `RV_OP_JALR: begin
                chk_imm    = 1'b1;
                exp_src    = WB_PC4;
                exp_taken  = !prev_busy;  // no prediction while rs1 in flight
                exp_target = (prev_rs1v + imm_i) & ~32'h1;
                exp_ill    = (f3 != 3'b000);
            end
            default: exp_ill = 1'b1;  // system, fence, custom
        endcase
        if (exp_ill) begin
            exp_wb    = 1'b0;
            exp_mem   = MEM_NONE;
            exp_taken = 1'b0;
        end
    end

    // wb_src undefined for illegal ops, masked on both sides
    assign exp_ctrl = {exp_mem, exp_ill ? 2'b00 : 2'(exp_src), exp_wb, f3,
                       prev_f.instr[11:7], exp_ill, prev_f.pc_plus4};
    assign act_ctrl = {ex_o.mem_type, exp_ill ? 2'b00 : 2'(ex_o.wb_src), ex_o.wb_en,
                       ex_o.funct3, ex_o.rd, ex_o.illegal, ex_o.pc_plus4};

    function automatic void record_fail(input string name, input logic [63:0] e,
                                        input logic [63:0] a);
        if (!fail_flag) begin  // keep the first one
            fail_flag = 1'b1;
            fail_name = name;
            fail_exp  = e;
            fail_act  = a;
        end
    endfunction

    // ==============================
    // assertions
    // ==============================
    a_reset: assert property (@(posedge clk) $past(!resetn) |->
        !ex_valid_o && !redirect_valid_o && (ex_o == '0) && (redirect_o == '0))
        else begin
            $error("outputs not cleared by reset");
            record_fail("reset", 64'd0, 64'($sampled(ex_valid_o)));
        end

    a_valid: assert property (@(posedge clk) disable iff (!resetn)
        ex_valid_o == $past(fetch_valid_i))
        else begin
            $error("ex_valid_o latency wrong");
            record_fail("latency", 64'($sampled(prev_valid)), 64'($sampled(ex_valid_o)));
        end

    a_op_a: assert property (@(posedge clk) disable iff (!resetn)
        prev_valid && chk_a |-> ex_o.op_a == exp_a)
        else begin
            $error("op_a mismatch");
            record_fail("op_a", 64'($sampled(exp_a)), 64'($sampled(ex_o.op_a)));
        end

    a_op_b: assert property (@(posedge clk) disable iff (!resetn)
        prev_valid && chk_b |-> ex_o.op_b == exp_b)
        else begin
            $error("op_b mismatch");
            record_fail("op_b", 64'($sampled(exp_b)), 64'($sampled(ex_o.op_b)));
        end

    a_imm: assert property (@(posedge clk) disable iff (!resetn)
        prev_valid && chk_imm |-> ex_o.imm == exp_imm)
        else begin
            $error("immediate mismatch");
            record_fail("imm", 64'($sampled(exp_imm)), 64'($sampled(ex_o.imm)));
        end

    a_alu: assert property (@(posedge clk) disable iff (!resetn)
        prev_valid && chk_alu |-> ex_o.alu_op == exp_alu)
        else begin
            $error("alu_op mismatch");
            record_fail("alu_op", 64'($sampled(exp_alu)), 64'($sampled(ex_o.alu_op)));
        end

    a_ctrl: assert property (@(posedge clk) disable iff (!resetn)
        prev_valid |-> act_ctrl == exp_ctrl)
        else begin
            $error("control fields mismatch");
            record_fail("ctrl", 64'($sampled(exp_ctrl)), 64'($sampled(act_ctrl)));
        end

    a_redir: assert property (@(posedge clk) disable iff (!resetn)
        redirect_valid_o == (prev_valid && exp_taken))
        else begin
            $error("redirect_valid_o mismatch");
            record_fail("redirect_valid", 64'($sampled(prev_valid && exp_taken)),
                        64'($sampled(redirect_valid_o)));
        end

    a_taken: assert property (@(posedge clk) disable iff (!resetn)
        prev_valid |-> redirect_o.taken == exp_taken)
        else begin
            $error("redirect taken flag mismatch");
            record_fail("redirect_taken", 64'($sampled(exp_taken)),
                        64'($sampled(redirect_o.taken)));
        end

    a_target: assert property (@(posedge clk) disable iff (!resetn)
        prev_valid && exp_taken |-> redirect_o.target == exp_target)
        else begin
            $error("redirect target mismatch");
            record_fail("redirect_target", 64'($sampled(exp_target)),
                        64'($sampled(redirect_o.target)));
        end

endmodule

bind id_stage id_stage_checker chk_i (.*);

// File: test/tb_id_stage.sv
`timescale 1ns/1ps
`include "rv_id_macros.svh"

module tb_id_stage;
    import rv_id_pkg::*;

    localparam int N_INSTR     = 64;
    localparam int WATCHDOG_NS = (N_INSTR + 64) * 20 * 2;

    logic       clk = 1'b0;
    logic       resetn;
    logic       fetch_valid;
    fetch_pkt_t fetch;
    wb_pkt_t    wb;
    logic       rs1_busy;
    logic       ex_valid;
    id_ex_pkt_t ex;
    logic       redirect_valid;
    redirect_t  redirect;
    xlen_t      seed;
    xlen_t      pc;

    id_stage dut_i (
        .clk              (clk),
        .resetn           (resetn),
        .fetch_valid_i    (fetch_valid),
        .fetch_i          (fetch),
        .wb_i             (wb),
        .rs1_busy_i       (rs1_busy),
        .ex_valid_o       (ex_valid),
        .ex_o             (ex),
        .redirect_valid_o (redirect_valid),
        .redirect_o       (redirect)
    );

    always #10 clk = ~clk;  // 20 ns period

    // ==============================
    // helpers
    // ==============================
    function automatic xlen_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic end_failed(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on a failure");
    endtask

    task automatic issue(input instr_t ins, input logic busy);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch       <= '{instr: ins, pc: pc, pc_plus4: pc + 32'd4};
        rs1_busy    <= busy;
        pc = pc + 32'd4;  // sequential, redirects not followed
    endtask

    task automatic idle();
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    // checker flag, first failure ends the run
    always @(posedge clk) begin
        if (dut_i.chk_i.fail_flag) begin
            end_failed($sformatf("FAILED %s expected %h actual %h", dut_i.chk_i.fail_name,
                                 dut_i.chk_i.fail_exp, dut_i.chk_i.fail_act));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        end_failed("timeout, the instruction program did not complete");
    end

    // ==============================
    // program
    // ==============================
    initial begin
        xlen_t  data;
        xlen_t  r;
        instr_t ins;
        logic   busy;

        seed        = 32'h5417_0638;
        pc          = 32'h0000_1000;
        resetn      = 1'b0;
        fetch_valid = 1'b0;
        fetch       = '0;
        wb          = '0;
        rs1_busy    = 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        // fill the register file, x0 write must be dropped
        for (int k = 0; k < `RV_NUM_REGS; k++) begin
            @(posedge clk);
            data = next_rand();
            wb <= '{en: 1'b1, rd: reg_idx_t'(k), data: data};
        end
        @(posedge clk);
        wb <= '0;

        // back-to-back first half, gaps in the second
        for (int i = 0; i < N_INSTR; i++) begin
            r    = next_rand();
            busy = r[1];
            case (i % 13)
                0:  ins = {7'h00, r[24:15], 3'b000, r[11:7], `RV_OP_REG};  // add
                1:  ins = {7'h20, r[24:15], 3'b000, r[11:7], `RV_OP_REG};  // sub
                2:  ins = {7'h00, 5'd0, r[19:15], 3'b111, r[11:7], `RV_OP_REG};  // and x0
                3:  ins = {r[31:15], 3'b000, r[11:7], `RV_OP_IMM};  // addi
                4:  ins = {r[31:15], 1'b0, (r[13] ? 2'b10 : {1'b0, r[12]}), r[11:7],
                           `RV_OP_STORE};
                5:  ins = {r[31:7], `RV_OP_LUI};
                6:  ins = {r[31:7], `RV_OP_AUIPC};
                7:  ins = {1'b1, r[30:15], 3'b000, r[11:7], `RV_OP_BRANCH};  // backward beq
                8:  ins = {1'b0, r[30:15], 3'b001, r[11:7], `RV_OP_BRANCH};  // forward bne
                9:  ins = {r[31:7], `RV_OP_JAL};
                10: begin
                    ins  = {r[31:15], 3'b000, r[11:7], `RV_OP_JALR};
                    busy = ((i / 13) % 2) == 1;  // alternate hazard level
                end
                11: ins = {r[31:15], (r[13] ? 3'b010 : {r[14], 1'b0, r[12]}), r[11:7],
                           `RV_OP_LOAD};  // lb, lh, lw, lbu, lhu
                default: ins = {r[31:7], (r[0] ? 7'b1110011 : 7'b0001011)};  // illegal
            endcase
            issue(ins, busy);
            if (i >= N_INSTR / 2 && (i % 2) == 1) begin
                idle();
            end
        end
        idle();
        repeat (3) @(posedge clk);

        if (dut_i.chk_i.fail_flag) begin
            end_failed($sformatf("FAILED %s expected %h actual %h", dut_i.chk_i.fail_name,
                                 dut_i.chk_i.fail_exp, dut_i.chk_i.fail_act));
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule
